/* build.f */
logic/cmac_ctrl_pkg.sv
logic/rx_bringup_fsm.sv
logic/tx_bringup_fsm.sv
logic/cmac_stat_counters.sv
logic/cmac_stat_regs.sv
logic/cmac_ctrl_top.sv
tests/cmac_ctrl_tb.sv

/* tests/cmac_ctrl_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// directed tests for bring-up, counters and the wishbone read port
// inputs change on the rising edge, outputs are sampled on the falling edge
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cmac_ctrl_tb;
    import cmac_ctrl_pkg::*;

    localparam int CNT_W = CNT_W_DEF;
    localparam int ERR_W = ERR_W_DEF;
    localparam int INC_W [8] = '{3, 1, 7, 14, 1, 1, 6, 14};  // increment widths, map order
    localparam int ERR_IN_W [7] = '{1, 3, 3, 1, 1, 1, 1};
    localparam int TIMEOUT_CYCLES = 4000;  // about 550 cycles of tests plus margin

    logic            gt_txusrclk2;
    logic            usr_rx_reset_w;
    logic            stat_rx_aligned, stat_rx_aligned_err;
    lane_err_t       stat_rx_bad_code, stat_rx_bad_fcs;
    logic            stat_rx_bad_preamble, stat_rx_bad_sfd;
    rx_pkts_inc_t    stat_rx_total_packets;
    logic            stat_rx_good_packets, stat_tx_total_packets, stat_tx_good_packets;
    rx_bytes_inc_t   stat_rx_total_bytes;
    tx_bytes_inc_t   stat_tx_total_bytes;
    good_bytes_inc_t stat_rx_good_bytes, stat_tx_good_bytes;
    logic            tx_ovf, tx_unf;
    logic            ctl_rx_enable, ctl_tx_enable, ctl_tx_send_lfi, ctl_tx_send_rfi;
    logic            wb_cyc, wb_stb, wb_we, wb_ack;
    stat_addr_t      wb_adr;
    wb_data_t        wb_dat_o;

    logic [63:0]     acc_sum [8];   // expected accumulator totals
    int              err_seen [7];  // cycles with a nonzero error input
    logic            ack_prev;

    cmac_ctrl_top i_cmac_ctrl_top (.*);

    initial begin
        gt_txusrclk2 = 1'b0;
        forever #2 gt_txusrclk2 = ~gt_txusrclk2;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    task automatic wb_access(input logic we, input stat_addr_t adr, output wb_data_t data);
        int waited;
        waited = 0;
        @(posedge gt_txusrclk2);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= we;
        wb_adr <= adr;
        do begin
            @(negedge gt_txusrclk2);
            waited++;
        end while (!wb_ack && waited < 8);
        assert (wb_ack) else abort_run($sformatf("no wb_ack for address %0d", adr));
        data = wb_dat_o;
        @(posedge gt_txusrclk2);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic reset_test;
        repeat (4) @(posedge gt_txusrclk2);
        @(negedge gt_txusrclk2);
        check_value("ctl_rx_enable", ctl_rx_enable, 0);
        check_value("ctl_tx_enable", ctl_tx_enable, 0);
        check_value("ctl_tx_send_lfi", ctl_tx_send_lfi, 0);
        check_value("ctl_tx_send_rfi", ctl_tx_send_rfi, 0);
        check_value("wb_ack", wb_ack, 0);
        @(posedge gt_txusrclk2);
        usr_rx_reset_w <= 1'b0;              // fifth reset cycle ends here
        repeat (3) @(posedge gt_txusrclk2);  // edges 0, 1 and 2
        @(negedge gt_txusrclk2);
        check_value("ctl_rx_enable", ctl_rx_enable, 1);
        check_value("ctl_tx_send_lfi", ctl_tx_send_lfi, 1);
        check_value("ctl_tx_send_rfi", ctl_tx_send_rfi, 1);
        check_value("ctl_tx_enable", ctl_tx_enable, 0);
    endtask

    task automatic align_test;
        @(posedge gt_txusrclk2);
        stat_rx_aligned <= 1'b1;
        // sampled at the next edge, outputs follow two edges after that
        repeat (3) @(posedge gt_txusrclk2);
        @(negedge gt_txusrclk2);
        check_value("ctl_tx_enable", ctl_tx_enable, 1);
        check_value("ctl_tx_send_lfi", ctl_tx_send_lfi, 0);
        check_value("ctl_tx_send_rfi", ctl_tx_send_rfi, 0);
        check_value("ctl_rx_enable", ctl_rx_enable, 1);
    endtask

    task automatic align_loss_test;
        int rx_low;
        rx_low = 0;
        @(posedge gt_txusrclk2);
        stat_rx_aligned <= 1'b0;
        repeat (5) begin  // sampling edge plus 4 cycles
            @(negedge gt_txusrclk2);
            if (!ctl_rx_enable) rx_low++;
        end
        check_value("ctl_tx_enable", ctl_tx_enable, 0);
        check_value("ctl_tx_send_lfi", ctl_tx_send_lfi, 1);
        check_value("ctl_tx_send_rfi", ctl_tx_send_rfi, 1);
        check_value("ctl_rx_enable", ctl_rx_enable, 1);
        check_value("ctl_rx_enable low cycles", rx_low, 1);
    endtask

    task automatic accumulator_test;
        logic [13:0] v [8];
        wb_data_t    rd;
        for (int i = 0; i < 8; i++) acc_sum[i] = '0;
        repeat (200) begin
            @(posedge gt_txusrclk2);
            for (int i = 0; i < 8; i++) begin
                v[i] = 14'($urandom_range(0, (1 << INC_W[i]) - 1));
                acc_sum[i] += v[i];
            end
            stat_rx_total_packets <= rx_pkts_inc_t'(v[0]);
            stat_rx_good_packets  <= v[1][0];
            stat_rx_total_bytes   <= rx_bytes_inc_t'(v[2]);
            stat_rx_good_bytes    <= v[3];
            stat_tx_total_packets <= v[4][0];
            stat_tx_good_packets  <= v[5][0];
            stat_tx_total_bytes   <= tx_bytes_inc_t'(v[6]);
            stat_tx_good_bytes    <= v[7];
        end
        @(posedge gt_txusrclk2);
        {stat_rx_total_packets, stat_rx_good_packets, stat_rx_total_bytes} <= '0;
        {stat_rx_good_bytes, stat_tx_total_packets, stat_tx_good_packets} <= '0;
        {stat_tx_total_bytes, stat_tx_good_bytes} <= '0;
        for (int i = 0; i < 8; i++) begin
            wb_access(1'b0, stat_addr_t'(i), rd);
            check_value($sformatf("wb_dat_o at address %0d", i), rd,
                        acc_sum[i] & ((64'd1 << CNT_W) - 1));
        end
    endtask

    task automatic error_counter_test;
        logic [2:0] e [7];
        wb_data_t   rd;
        for (int j = 0; j < 7; j++) err_seen[j] = 0;
        repeat (200) begin
            @(posedge gt_txusrclk2);
            for (int j = 0; j < 7; j++) begin
                e[j] = 3'($urandom_range(0, (1 << ERR_IN_W[j]) - 1));
                if (e[j] != 0) err_seen[j]++;
            end
            stat_rx_aligned_err  <= e[0][0];
            stat_rx_bad_code     <= e[1];
            stat_rx_bad_fcs      <= e[2];
            stat_rx_bad_preamble <= e[3][0];
            stat_rx_bad_sfd      <= e[4][0];
            tx_ovf               <= e[5][0];
            tx_unf               <= e[6][0];
        end
        @(posedge gt_txusrclk2);
        {stat_rx_aligned_err, stat_rx_bad_code, stat_rx_bad_fcs} <= '0;
        {stat_rx_bad_preamble, stat_rx_bad_sfd, tx_ovf, tx_unf} <= '0;
        for (int j = 0; j < 7; j++) begin
            wb_access(1'b0, stat_addr_t'(8 + j), rd);
            check_value($sformatf("wb_dat_o at address %0d", 8 + j), rd,
                        64'(err_seen[j]) & ((64'd1 << ERR_W) - 1));
        end
    endtask

    task automatic bus_rules_test;
        wb_data_t rd;
        wb_access(1'b0, 4'd15, rd);
        check_value("wb_dat_o at address 15", rd, 0);
        wb_access(1'b1, 4'd0, rd);  // must be acked, contents ignored
        wb_access(1'b0, 4'd0, rd);
        check_value("wb_dat_o at address 0 after write", rd,
                    acc_sum[0] & ((64'd1 << CNT_W) - 1));
    endtask

    // ack must drop after every acked cycle
    always @(negedge gt_txusrclk2) begin
        if (!usr_rx_reset_w) begin
            assert (!(ack_prev && wb_ack)) else abort_run("wb_ack stayed high for two cycles");
        end
        ack_prev = wb_ack;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge gt_txusrclk2);
        abort_run("timeout, tests did not finish in time");
    end

    initial begin
        void'($urandom(32'hcdcf3425));
        ack_prev       = 1'b0;
        usr_rx_reset_w = 1'b1;
        {stat_rx_aligned, stat_rx_aligned_err, stat_rx_bad_code, stat_rx_bad_fcs} = '0;
        {stat_rx_bad_preamble, stat_rx_bad_sfd, tx_ovf, tx_unf} = '0;
        {stat_rx_total_packets, stat_rx_good_packets, stat_rx_total_bytes} = '0;
        {stat_rx_good_bytes, stat_tx_total_packets, stat_tx_good_packets} = '0;
        {stat_tx_total_bytes, stat_tx_good_bytes} = '0;
        {wb_cyc, wb_stb, wb_we, wb_adr} = '0;
        reset_test();
        align_test();
        align_loss_test();
        accumulator_test();
        error_counter_test();
        bus_rules_test();
        $display("Simulation passed");
        $finish;
    end

endmodule

/* logic/cmac_ctrl_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// single clock, single sync reset; MAC status must be on gt_txusrclk2
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cmac_ctrl_top (
    input  logic                           gt_txusrclk2,
    input  logic                           usr_rx_reset_w,
    input  logic                           stat_rx_aligned,
    input  logic                           stat_rx_aligned_err,
    input  cmac_ctrl_pkg::lane_err_t       stat_rx_bad_code,
    input  cmac_ctrl_pkg::lane_err_t       stat_rx_bad_fcs,
    input  logic                           stat_rx_bad_preamble,
    input  logic                           stat_rx_bad_sfd,
    input  cmac_ctrl_pkg::rx_pkts_inc_t    stat_rx_total_packets,
    input  logic                           stat_rx_good_packets,
    input  cmac_ctrl_pkg::rx_bytes_inc_t   stat_rx_total_bytes,
    input  cmac_ctrl_pkg::good_bytes_inc_t stat_rx_good_bytes,
    input  logic                           stat_tx_total_packets,
    input  logic                           stat_tx_good_packets,
    input  cmac_ctrl_pkg::tx_bytes_inc_t   stat_tx_total_bytes,
    input  cmac_ctrl_pkg::good_bytes_inc_t stat_tx_good_bytes,
    input  logic                           tx_ovf,
    input  logic                           tx_unf,
    output logic                           ctl_rx_enable,
    output logic                           ctl_tx_enable,
    output logic                           ctl_tx_send_lfi,
    output logic                           ctl_tx_send_rfi,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  cmac_ctrl_pkg::stat_addr_t      wb_adr,
    output cmac_ctrl_pkg::wb_data_t        wb_dat_o,
    output logic                           wb_ack
);
    import cmac_ctrl_pkg::*;

    localparam int CNT_W = CNT_W_DEF;
    localparam int ERR_W = ERR_W_DEF;

    if (CNT_W > 32 || CNT_W < 14) begin : g_cnt_w_check
        $error("CNT_W must be within 14 to 32");
    end

    logic             rx_aligned_q;
    logic             ctl_tx_send_fault;
    logic [CNT_W-1:0] acc_cnt [8];
    logic [ERR_W-1:0] err_cnt [7];

    // local and remote fault always go out together
    assign ctl_tx_send_lfi = ctl_tx_send_fault;
    assign ctl_tx_send_rfi = ctl_tx_send_fault;

    rx_bringup_fsm i_rx_bringup_fsm (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .stat_rx_aligned(stat_rx_aligned),
        .ctl_rx_enable  (ctl_rx_enable),
        .rx_aligned_q   (rx_aligned_q)
    );

    tx_bringup_fsm i_tx_bringup_fsm (
        .gt_txusrclk2     (gt_txusrclk2),
        .usr_rx_reset_w   (usr_rx_reset_w),
        .rx_aligned_q     (rx_aligned_q),
        .ctl_tx_enable    (ctl_tx_enable),
        .ctl_tx_send_fault(ctl_tx_send_fault)
    );

    cmac_stat_counters #(
        .CNT_W(CNT_W),
        .ERR_W(ERR_W)
    ) i_cmac_stat_counters (
        .gt_txusrclk2         (gt_txusrclk2),
        .usr_rx_reset_w       (usr_rx_reset_w),
        .stat_rx_total_packets(stat_rx_total_packets),
        .stat_rx_good_packets (stat_rx_good_packets),
        .stat_rx_total_bytes  (stat_rx_total_bytes),
        .stat_rx_good_bytes   (stat_rx_good_bytes),
        .stat_tx_total_packets(stat_tx_total_packets),
        .stat_tx_good_packets (stat_tx_good_packets),
        .stat_tx_total_bytes  (stat_tx_total_bytes),
        .stat_tx_good_bytes   (stat_tx_good_bytes),
        .stat_rx_aligned_err  (stat_rx_aligned_err),
        .stat_rx_bad_code     (stat_rx_bad_code),
        .stat_rx_bad_fcs      (stat_rx_bad_fcs),
        .stat_rx_bad_preamble (stat_rx_bad_preamble),
        .stat_rx_bad_sfd      (stat_rx_bad_sfd),
        .tx_ovf               (tx_ovf),
        .tx_unf               (tx_unf),
        .acc_cnt              (acc_cnt),
        .err_cnt              (err_cnt)
    );

    cmac_stat_regs #(
        .CNT_W(CNT_W),
        .ERR_W(ERR_W)
    ) i_cmac_stat_regs (
        .gt_txusrclk2  (gt_txusrclk2),
        .usr_rx_reset_w(usr_rx_reset_w),
        .acc_cnt       (acc_cnt),
        .err_cnt       (err_cnt),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_o      (wb_dat_o),
        .wb_ack        (wb_ack)
    );

endmodule

/* logic/cmac_stat_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~
// read-only wishbone classic slave, writes are acked and dropped
// held requests get an ack every second cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cmac_stat_regs #(
    parameter int CNT_W = cmac_ctrl_pkg::CNT_W_DEF,
    parameter int ERR_W = cmac_ctrl_pkg::ERR_W_DEF
) (
    input  logic                      gt_txusrclk2,
    input  logic                      usr_rx_reset_w,
    input  logic [CNT_W-1:0]          acc_cnt [8],
    input  logic [ERR_W-1:0]          err_cnt [7],
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  cmac_ctrl_pkg::stat_addr_t wb_adr,
    output cmac_ctrl_pkg::wb_data_t   wb_dat_o,
    output logic                      wb_ack
);
    import cmac_ctrl_pkg::*;

    wb_data_t rd_word;
    logic     wb_req;

    assign wb_req = wb_cyc & wb_stb & ~wb_ack;  // new access only

    always_comb begin
        rd_word = '0;
        if (!wb_we) begin
            case (stat_reg_e'(wb_adr)) inside
                [STAT_RX_TOTAL_PKTS:STAT_TX_GOOD_BYTES]: begin
                    rd_word = wb_data_t'(acc_cnt[wb_adr[2:0]]);
                end
                [STAT_ERR_ALIGN:STAT_TX_UNF]: begin
                    rd_word = wb_data_t'(err_cnt[3'(wb_adr - STAT_ERR_ALIGN)]);
                end
                default: begin
                    rd_word = '0;  // unmapped
                end
            endcase
        end
    end

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // read word only needs to be valid with ack
    always_ff @(posedge gt_txusrclk2) begin
        if (wb_req) begin
            wb_dat_o <= rd_word;
        end
    end

    a_ack_single: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles");

endmodule

/* logic/cmac_stat_counters.sv */
// ~~~~~~~~~~~~~~~~~~~~
// all counters wrap silently
// CNT_W must be at least 14 to hold one good-bytes increment
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cmac_stat_counters #(
    parameter int CNT_W = cmac_ctrl_pkg::CNT_W_DEF,
    parameter int ERR_W = cmac_ctrl_pkg::ERR_W_DEF
) (
    input  logic                           gt_txusrclk2,
    input  logic                           usr_rx_reset_w,
    input  cmac_ctrl_pkg::rx_pkts_inc_t    stat_rx_total_packets,
    input  logic                           stat_rx_good_packets,
    input  cmac_ctrl_pkg::rx_bytes_inc_t   stat_rx_total_bytes,
    input  cmac_ctrl_pkg::good_bytes_inc_t stat_rx_good_bytes,
    input  logic                           stat_tx_total_packets,
    input  logic                           stat_tx_good_packets,
    input  cmac_ctrl_pkg::tx_bytes_inc_t   stat_tx_total_bytes,
    input  cmac_ctrl_pkg::good_bytes_inc_t stat_tx_good_bytes,
    input  logic                           stat_rx_aligned_err,
    input  cmac_ctrl_pkg::lane_err_t       stat_rx_bad_code,
    input  cmac_ctrl_pkg::lane_err_t       stat_rx_bad_fcs,
    input  logic                           stat_rx_bad_preamble,
    input  logic                           stat_rx_bad_sfd,
    input  logic                           tx_ovf,
    input  logic                           tx_unf,
    output logic [CNT_W-1:0]               acc_cnt [8],
    output logic [ERR_W-1:0]               err_cnt [7]
);

    logic [CNT_W-1:0] acc_inc [8];  // increments, register-map order
    logic [6:0]       err_hit;

    always_comb begin
        acc_inc[0] = CNT_W'(stat_rx_total_packets);
        acc_inc[1] = CNT_W'(stat_rx_good_packets);
        acc_inc[2] = CNT_W'(stat_rx_total_bytes);
        acc_inc[3] = CNT_W'(stat_rx_good_bytes);
        acc_inc[4] = CNT_W'(stat_tx_total_packets);
        acc_inc[5] = CNT_W'(stat_tx_good_packets);
        acc_inc[6] = CNT_W'(stat_tx_total_bytes);
        acc_inc[7] = CNT_W'(stat_tx_good_bytes);
    end

    // one event per cycle, however many lanes report it
    assign err_hit = {tx_unf,
                      tx_ovf,
                      stat_rx_bad_sfd,
                      stat_rx_bad_preamble,
                      |stat_rx_bad_fcs,
                      |stat_rx_bad_code,
                      stat_rx_aligned_err};

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            for (int i = 0; i < 8; i++) begin
                acc_cnt[i] <= '0;
            end
            for (int j = 0; j < 7; j++) begin
                err_cnt[j] <= '0;
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                acc_cnt[i] <= acc_cnt[i] + acc_inc[i];
            end
            for (int j = 0; j < 7; j++) begin
                if (err_hit[j]) begin
                    err_cnt[j] <= err_cnt[j] + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/tx_bringup_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~
// sends lfi/rfi until the receiver reports alignment
// rx_aligned_q comes registered from the rx state machine
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tx_bringup_fsm (
    input  logic gt_txusrclk2,
    input  logic usr_rx_reset_w,
    input  logic rx_aligned_q,
    output logic ctl_tx_enable,
    output logic ctl_tx_send_fault
);
    import cmac_ctrl_pkg::*;

    tx_state_t tx_state;
    logic      tx_reset_done;

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            tx_state          <= TX_IDLE;
            ctl_tx_enable     <= 1'b0;
            ctl_tx_send_fault <= 1'b0;
            tx_reset_done     <= 1'b0;
        end else begin
            tx_reset_done <= 1'b1;
            case (tx_state)
                TX_IDLE: begin
                    ctl_tx_enable     <= 1'b0;
                    ctl_tx_send_fault <= 1'b0;
                    if (tx_reset_done) begin
                        tx_state <= TX_GT_LOCKED;
                    end
                end
                TX_GT_LOCKED: begin
                    // tell the link partner we are not ready yet
                    ctl_tx_enable     <= 1'b0;
                    ctl_tx_send_fault <= 1'b1;
                    tx_state          <= TX_WAIT_ALIGNED;
                end
                TX_WAIT_ALIGNED: begin
                    if (rx_aligned_q) begin
                        tx_state <= TX_PKT_TRANSFER;
                    end
                end
                TX_PKT_TRANSFER: begin
                    ctl_tx_send_fault <= 1'b0;
                    ctl_tx_enable     <= 1'b1;
                    if (!rx_aligned_q) begin
                        tx_state <= TX_IDLE;  // lost alignment
                    end
                end
                default: begin
                    tx_state <= TX_IDLE;
                end
            endcase
        end
    end

    a_enable_xor_fault: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        !(ctl_tx_enable && ctl_tx_send_fault))
        else $error("ctl_tx_enable and ctl_tx_send_fault both high");

endmodule

/* logic/rx_bringup_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~
// rx enable rises two cycles after reset release
// stat_rx_aligned must already be in the gt_txusrclk2 domain
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module rx_bringup_fsm (
    input  logic gt_txusrclk2,
    input  logic usr_rx_reset_w,
    input  logic stat_rx_aligned,
    output logic ctl_rx_enable,
    output logic rx_aligned_q
);
    import cmac_ctrl_pkg::*;

    rx_state_t rx_state;
    logic      rx_reset_done;

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rx_state      <= RX_IDLE;
            ctl_rx_enable <= 1'b0;
            rx_aligned_q  <= 1'b0;
            rx_reset_done <= 1'b0;
        end else begin
            rx_reset_done <= 1'b1;
            rx_aligned_q  <= stat_rx_aligned;  // one cycle late, shared with tx side
            case (rx_state)
                RX_IDLE: begin
                    ctl_rx_enable <= 1'b0;
                    if (rx_reset_done) begin
                        rx_state <= RX_GT_LOCKED;
                    end
                end
                RX_GT_LOCKED: begin
                    ctl_rx_enable <= 1'b1;  // stays on until alignment drops
                    rx_state      <= RX_WAIT_ALIGNED;
                end
                RX_WAIT_ALIGNED: begin
                    if (rx_aligned_q) begin
                        rx_state <= RX_PKT_TRANSFER;
                    end
                end
                RX_PKT_TRANSFER: begin
                    if (!rx_aligned_q) begin
                        rx_state <= RX_IDLE;  // restart bring-up
                    end
                end
                default: begin
                    rx_state <= RX_IDLE;
                end
            endcase
        end
    end

    // idle clears the enable on its way out, so it is low the cycle after
    a_idle_disables_rx: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        (rx_state == RX_IDLE) |=> !ctl_rx_enable)
        else $error("ctl_rx_enable high after RX_IDLE");

endmodule

/* logic/cmac_ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// shared types for the MAC bring-up and statistics logic
// increment widths follow the MAC status outputs
// ~~~~~~~~~~~~~~~~~~~~

package cmac_ctrl_pkg;

    // default counter widths, the top level passes them down
    localparam int CNT_W_DEF = 32;  // 14 to 32
    localparam int ERR_W_DEF = 16;

    typedef enum logic [3:0] {
        RX_IDLE         = 4'd0,
        RX_GT_LOCKED    = 4'd1,
        RX_WAIT_ALIGNED = 4'd2,
        RX_PKT_TRANSFER = 4'd3
    } rx_state_t;

    typedef enum logic [3:0] {
        TX_IDLE         = 4'd0,
        TX_GT_LOCKED    = 4'd1,
        TX_WAIT_ALIGNED = 4'd2,
        TX_PKT_TRANSFER = 4'd3
    } tx_state_t;

    typedef logic [6:0]  rx_bytes_inc_t;    // all rx bytes per cycle
    typedef logic [5:0]  tx_bytes_inc_t;    // all tx bytes per cycle
    typedef logic [13:0] good_bytes_inc_t;  // good bytes, rx and tx
    typedef logic [2:0]  rx_pkts_inc_t;
    typedef logic [2:0]  lane_err_t;        // bad code / bad fcs count

    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  stat_addr_t;       // word address

    // statistics register map, address 15 reads zero
    typedef enum stat_addr_t {
        STAT_RX_TOTAL_PKTS  = 4'd0,
        STAT_RX_GOOD_PKTS   = 4'd1,
        STAT_RX_TOTAL_BYTES = 4'd2,
        STAT_RX_GOOD_BYTES  = 4'd3,
        STAT_TX_TOTAL_PKTS  = 4'd4,
        STAT_TX_GOOD_PKTS   = 4'd5,
        STAT_TX_TOTAL_BYTES = 4'd6,
        STAT_TX_GOOD_BYTES  = 4'd7,
        STAT_ERR_ALIGN      = 4'd8,
        STAT_ERR_CODE       = 4'd9,
        STAT_ERR_FCS        = 4'd10,
        STAT_ERR_PREAMBLE   = 4'd11,
        STAT_ERR_SFD        = 4'd12,
        STAT_TX_OVF         = 4'd13,
        STAT_TX_UNF         = 4'd14
    } stat_reg_e;

endpackage
